//--- common/rx_core_settings.svh
`ifndef RX_CORE_SETTINGS_SVH
`define RX_CORE_SETTINGS_SVH

////////////////////////////////////////////////////////////
// lane and data widths
////////////////////////////////////////////////////////////

// time-interleaved lanes per clk_adc cycle
`define RX_NTI 8
// adc magnitude bits, sign travels separately
`define RX_NADC 8

////////////////////////////////////////////////////////////
// phase interpolator control
////////////////////////////////////////////////////////////

`define RX_NPI 8
`define RX_NOUT 4
`define RX_NMAXSEL 4
// default scale is ((max_sel + 1) << shift) - 1
`define RX_SCALE_SHIFT 4

////////////////////////////////////////////////////////////
// prbs, reset wait and counters
////////////////////////////////////////////////////////////

// prbs7, taps at 7 and 6
`define RX_PRBS_LEN 7
`define RX_CTL_WAIT 32
`define RX_COUNT_W 32

`endif

//--- common/adc_pkg.sv
`default_nettype none

`include "rx_core_settings.svh"

package adc_pkg;

    ////////////////////////////////////////////////////////////
    // adc data path types
    ////////////////////////////////////////////////////////////

    // raw magnitude of one lane
    typedef logic [`RX_NADC-1:0] adc_mag_t;

    // one extra bit over the magnitude for the sign
    typedef logic signed [`RX_NADC:0] unfolded_t;

    // offset removed after unfolding
    typedef logic signed [`RX_NADC-1:0] offset_t;

    // one decision bit per lane
    // bit 0 is the earliest sample in time
    typedef logic [`RX_NTI-1:0] lane_bits_t;

endpackage

`default_nettype wire

//--- common/ctl_pkg.sv
`default_nettype none

`include "rx_core_settings.svh"

package ctl_pkg;

    ////////////////////////////////////////////////////////////
    // control side types
    ////////////////////////////////////////////////////////////

    // checker input source
    typedef enum logic {
        SRC_ADC  = 1'b0,
        SRC_BIST = 1'b1
    } prbs_src_e;

    // pi codes, scales and offsets
    typedef logic [`RX_NPI-1:0] pi_code_t;

    // coarse range select per pi output
    typedef logic [`RX_NMAXSEL-1:0] max_sel_t;

    // error and bit counters
    typedef logic [`RX_COUNT_W-1:0] count_t;

endpackage

`default_nettype wire

//--- source/rx_control.sv
`timescale 1ns/1ps
`default_nettype none

`include "rx_core_settings.svh"

module rx_control (
    input  wire                   clk_adc,
    input  wire                   cdr_rstb,
    input  wire ctl_pkg::prbs_src_e prbs_src_i,
    input  wire logic             chk_en_i,
    input  wire logic             chk_clear_i,
    output logic                  ctl_valid_o,
    output logic                  check_en_o,
    output logic                  chk_clr_o,
    output ctl_pkg::prbs_src_e    sel_src_o
);
    import ctl_pkg::*;

    localparam int WAIT_W = $clog2(`RX_CTL_WAIT);
    localparam logic [WAIT_W-1:0] WAIT_LAST = WAIT_W'(`RX_CTL_WAIT - 1);

    logic [WAIT_W-1:0] wait_cnt;
    logic              ctl_valid_q;
    prbs_src_e         sel_src_q;

    ////////////////////////////////////////////////////////////
    // post-reset wait
    ////////////////////////////////////////////////////////////

    // counter saturates, valid rises on the edge after it tops out
    always_ff @(posedge clk_adc or negedge cdr_rstb) begin
        if (!cdr_rstb) begin
            wait_cnt    <= '0;
            ctl_valid_q <= 1'b0;
        end else begin
            if (wait_cnt != WAIT_LAST) begin
                wait_cnt <= wait_cnt + 1'b1;
            end
            ctl_valid_q <= (wait_cnt == WAIT_LAST);
        end
    end

    ////////////////////////////////////////////////////////////
    // source select and checker clear
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk_adc or negedge cdr_rstb) begin
        if (!cdr_rstb) begin
            sel_src_q <= SRC_ADC;
        end else begin
            sel_src_q <= prbs_src_i;
        end
    end

    // clear lands on the same edge that switches the checker source
    assign chk_clr_o   = chk_clear_i | (prbs_src_i != sel_src_q);
    assign check_en_o  = ctl_valid_q & chk_en_i;
    assign ctl_valid_o = ctl_valid_q;
    assign sel_src_o   = sel_src_q;

    // downstream pi and checker logic rely on a sticky valid
    a_valid_sticky: assert property (
        @(posedge clk_adc) disable iff (!cdr_rstb)
        ctl_valid_q |=> ctl_valid_q
    );

endmodule

`default_nettype wire

//--- source/adc_unfold_slice.sv
`timescale 1ns/1ps
`default_nettype none

`include "rx_core_settings.svh"

module adc_unfold_slice (
    input  wire                      clk_adc,
    input  wire                      cdr_rstb,
    input  wire adc_pkg::adc_mag_t   adc_mag_i [`RX_NTI-1:0],
    input  wire adc_pkg::lane_bits_t adc_sign_i,
    input  wire adc_pkg::offset_t    adc_offset_i,
    input  wire adc_pkg::unfolded_t  slice_thresh_i,
    output adc_pkg::unfolded_t       unfolded_o [`RX_NTI-1:0],
    output adc_pkg::lane_bits_t      adc_bits_o
);
    import adc_pkg::*;

    unfolded_t  mag_ext    [`RX_NTI-1:0];
    unfolded_t  unfold_d   [`RX_NTI-1:0];
    unfolded_t  unfolded_q [`RX_NTI-1:0];
    unfolded_t  offset_ext;
    lane_bits_t slice_d;
    lane_bits_t adc_bits_q;

    // sign extend the offset once for all lanes
    assign offset_ext = unfolded_t'(adc_offset_i);

    ////////////////////////////////////////////////////////////
    // stage 1: unfold and remove offset
    ////////////////////////////////////////////////////////////

    // sign bit 1 means positive
    // extreme magnitude and offset together wrap in the code width
    always_comb begin
        for (int k = 0; k < `RX_NTI; k++) begin
            mag_ext[k]  = unfolded_t'({1'b0, adc_mag_i[k]});
            unfold_d[k] = (adc_sign_i[k] ? mag_ext[k] : -mag_ext[k]) - offset_ext;
        end
    end

    always_ff @(posedge clk_adc or negedge cdr_rstb) begin
        if (!cdr_rstb) begin
            for (int k = 0; k < `RX_NTI; k++) begin
                unfolded_q[k] <= '0;
            end
        end else begin
            for (int k = 0; k < `RX_NTI; k++) begin
                unfolded_q[k] <= unfold_d[k];
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // stage 2: threshold slicer
    ////////////////////////////////////////////////////////////

    // signed compare, equal to threshold slices to 0
    always_comb begin
        for (int k = 0; k < `RX_NTI; k++) begin
            slice_d[k] = (unfolded_q[k] > slice_thresh_i);
        end
    end

    always_ff @(posedge clk_adc or negedge cdr_rstb) begin
        if (!cdr_rstb) begin
            adc_bits_q <= '0;
        end else begin
            adc_bits_q <= slice_d;
        end
    end

    assign unfolded_o = unfolded_q;
    assign adc_bits_o = adc_bits_q;

endmodule

`default_nettype wire

//--- source/pi_ctl_scale.sv
`timescale 1ns/1ps
`default_nettype none

`include "rx_core_settings.svh"

module pi_ctl_scale (
    input  wire                    clk_adc,
    input  wire                    cdr_rstb,
    input  wire ctl_pkg::pi_code_t pi_code_i [`RX_NOUT-1:0],
    input  wire ctl_pkg::max_sel_t max_sel_i [`RX_NOUT-1:0],
    input  wire logic              ext_scale_en_i,
    input  wire ctl_pkg::pi_code_t ext_scale_i [`RX_NOUT-1:0],
    input  wire ctl_pkg::pi_code_t pi_offset_i [`RX_NOUT-1:0],
    output ctl_pkg::pi_code_t      pi_ctl_o [`RX_NOUT-1:0]
);
    import ctl_pkg::*;

    // one guard bit so (max_sel + 1) << shift does not wrap
    logic [`RX_NPI:0] sel_plus1  [`RX_NOUT-1:0];
    logic [`RX_NPI:0] dflt_scale [`RX_NOUT-1:0];
    pi_code_t         scale      [`RX_NOUT-1:0];
    pi_code_t         pi_ctl_q   [`RX_NOUT-1:0];

    always_comb begin
        for (int j = 0; j < `RX_NOUT; j++) begin
            sel_plus1[j]  = {{(`RX_NPI - `RX_NMAXSEL + 1){1'b0}}, max_sel_i[j]} + 1'b1;
            dflt_scale[j] = (sel_plus1[j] << `RX_SCALE_SHIFT) - 1'b1;
            scale[j]      = ext_scale_en_i ? ext_scale_i[j] : dflt_scale[j][`RX_NPI-1:0];
        end
    end

    // wrap code into the scale range, then shift by the offset
    always_ff @(posedge clk_adc or negedge cdr_rstb) begin
        if (!cdr_rstb) begin
            for (int j = 0; j < `RX_NOUT; j++) begin
                pi_ctl_q[j] <= '0;
            end
        end else begin
            for (int j = 0; j < `RX_NOUT; j++) begin
                pi_ctl_q[j] <= (pi_code_i[j] % scale[j]) + pi_offset_i[j];
            end
        end
    end

    assign pi_ctl_o = pi_ctl_q;

    for (genvar j = 0; j < `RX_NOUT; j++) begin : g_scale_chk
        a_scale_nonzero: assert property (
            @(posedge clk_adc) disable iff (!cdr_rstb) scale[j] != '0
        );
    end

endmodule

`default_nettype wire

//--- prbs/prbs_bist_gen.sv
`timescale 1ns/1ps
`default_nettype none

`include "rx_core_settings.svh"

module prbs_bist_gen (
    input  wire                      clk_adc,
    input  wire                      cdr_rstb,
    input  wire logic                gen_en_i,
    input  wire logic                gen_inj_err_i,
    output adc_pkg::lane_bits_t      bist_bits_o
);
    import adc_pkg::*;

    localparam int L = `RX_PRBS_LEN;

    // state[0] is the newest bit, state[k] is k+1 places back
    logic [L-1:0] state_q;
    logic [L-1:0] state_d;
    lane_bits_t   word_d;
    lane_bits_t   bist_q;

    ////////////////////////////////////////////////////////////
    // unrolled lfsr, RX_NTI steps per cycle
    ////////////////////////////////////////////////////////////

    always_comb begin
        state_d = state_q;
        for (int i = 0; i < `RX_NTI; i++) begin
            word_d[i] = state_d[L-1] ^ state_d[L-2];
            state_d   = {state_d[L-2:0], word_d[i]};
        end
    end

    // injected error flips lane 0 only, state runs on clean
    always_ff @(posedge clk_adc or negedge cdr_rstb) begin
        if (!cdr_rstb) begin
            state_q <= '1;
            bist_q  <= '0;
        end else if (gen_en_i) begin
            state_q <= state_d;
            bist_q  <= word_d ^ lane_bits_t'(gen_inj_err_i);
        end
    end

    assign bist_bits_o = bist_q;

    // lock-up state of the lfsr
    a_state_live: assert property (
        @(posedge clk_adc) disable iff (!cdr_rstb) state_q != '0
    );

endmodule

`default_nettype wire

//--- prbs/prbs_rx_checker.sv
`timescale 1ns/1ps
`default_nettype none

`include "rx_core_settings.svh"

module prbs_rx_checker (
    input  wire                       clk_adc,
    input  wire                       cdr_rstb,
    input  wire adc_pkg::lane_bits_t  adc_bits_i,
    input  wire adc_pkg::lane_bits_t  bist_bits_i,
    input  wire ctl_pkg::prbs_src_e   sel_src_i,
    input  wire logic                 check_en_i,
    input  wire logic                 clr_i,
    output ctl_pkg::count_t           err_count_o,
    output ctl_pkg::count_t           total_count_o
);
    import adc_pkg::*;
    import ctl_pkg::*;

    localparam int L     = `RX_PRBS_LEN;
    localparam int NUM_W = $clog2(`RX_NTI + 1);

    lane_bits_t       rx_bits;
    lane_bits_t       mismatch;
    logic [L-1:0]     hist_q;
    logic [L-1:0]     hist_d;
    logic             hist_valid_q;
    logic [NUM_W-1:0] err_num;
    count_t           err_cnt_q;
    count_t           total_cnt_q;

    assign rx_bits = (sel_src_i == SRC_BIST) ? bist_bits_i : adc_bits_i;

    ////////////////////////////////////////////////////////////
    // self-synchronised prediction
    ////////////////////////////////////////////////////////////

    // each bit predicted from the received stream itself
    // hist[0] newest, so after a full word hist holds its last L bits
    always_comb begin
        hist_d  = hist_q;
        err_num = '0;
        for (int i = 0; i < `RX_NTI; i++) begin
            mismatch[i] = rx_bits[i] ^ hist_d[L-1] ^ hist_d[L-2];
            err_num     = err_num + NUM_W'(mismatch[i]);
            hist_d      = {hist_d[L-2:0], rx_bits[i]};
        end
    end

    ////////////////////////////////////////////////////////////
    // history and counters
    ////////////////////////////////////////////////////////////

    // first enabled cycle after a clear only primes the history
    always_ff @(posedge clk_adc or negedge cdr_rstb) begin
        if (!cdr_rstb) begin
            hist_q       <= '0;
            hist_valid_q <= 1'b0;
            err_cnt_q    <= '0;
            total_cnt_q  <= '0;
        end else if (clr_i) begin
            hist_valid_q <= 1'b0;
            err_cnt_q    <= '0;
            total_cnt_q  <= '0;
        end else if (check_en_i) begin
            hist_q       <= hist_d;
            hist_valid_q <= 1'b1;
            if (hist_valid_q) begin
                err_cnt_q   <= err_cnt_q + count_t'(err_num);
                total_cnt_q <= total_cnt_q + count_t'(`RX_NTI);
            end
        end
    end

    assign err_count_o   = err_cnt_q;
    assign total_count_o = total_cnt_q;

    a_err_le_total: assert property (
        @(posedge clk_adc) disable iff (!cdr_rstb) err_cnt_q <= total_cnt_q
    );

endmodule

`default_nettype wire

//--- source/rx_core_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "rx_core_settings.svh"

module rx_core_top (
    input  wire                   clk_adc,
    input  wire                   cdr_rstb,

    // adc lanes
    input  wire adc_pkg::adc_mag_t  adc_mag_i [`RX_NTI-1:0],
    input  wire adc_pkg::lane_bits_t adc_sign_i,
    input  wire adc_pkg::offset_t   adc_offset_i,
    input  wire adc_pkg::unfolded_t slice_thresh_i,

    // prbs test controls
    input  wire ctl_pkg::prbs_src_e prbs_src_i,
    input  wire logic               chk_en_i,
    input  wire logic               chk_clear_i,
    input  wire logic               gen_en_i,
    input  wire logic               gen_inj_err_i,

    // pi code scaling
    input  wire ctl_pkg::pi_code_t  pi_code_i [`RX_NOUT-1:0],
    input  wire ctl_pkg::max_sel_t  max_sel_i [`RX_NOUT-1:0],
    input  wire logic               ext_scale_en_i,
    input  wire ctl_pkg::pi_code_t  ext_scale_i [`RX_NOUT-1:0],
    input  wire ctl_pkg::pi_code_t  pi_offset_i [`RX_NOUT-1:0],

    output logic                    ctl_valid_o,
    output adc_pkg::unfolded_t      unfolded_o [`RX_NTI-1:0],
    output ctl_pkg::count_t         prbs_err_count_o,
    output ctl_pkg::count_t         prbs_total_count_o,
    output ctl_pkg::pi_code_t       pi_ctl_o [`RX_NOUT-1:0]
);
    import adc_pkg::*;
    import ctl_pkg::*;

    logic       check_en;
    logic       chk_clr;
    prbs_src_e  sel_src;
    lane_bits_t adc_bits;
    lane_bits_t bist_bits;

    rx_control rx_control_i (
        .clk_adc     (clk_adc),
        .cdr_rstb    (cdr_rstb),
        .prbs_src_i  (prbs_src_i),
        .chk_en_i    (chk_en_i),
        .chk_clear_i (chk_clear_i),
        .ctl_valid_o (ctl_valid_o),
        .check_en_o  (check_en),
        .chk_clr_o   (chk_clr),
        .sel_src_o   (sel_src)
    );

    adc_unfold_slice adc_unfold_slice_i (
        .clk_adc        (clk_adc),
        .cdr_rstb       (cdr_rstb),
        .adc_mag_i      (adc_mag_i),
        .adc_sign_i     (adc_sign_i),
        .adc_offset_i   (adc_offset_i),
        .slice_thresh_i (slice_thresh_i),
        .unfolded_o     (unfolded_o),
        .adc_bits_o     (adc_bits)
    );

    // bist pattern source
    prbs_bist_gen prbs_bist_gen_i (
        .clk_adc       (clk_adc),
        .cdr_rstb      (cdr_rstb),
        .gen_en_i      (gen_en_i),
        .gen_inj_err_i (gen_inj_err_i),
        .bist_bits_o   (bist_bits)
    );

    prbs_rx_checker prbs_rx_checker_i (
        .clk_adc       (clk_adc),
        .cdr_rstb      (cdr_rstb),
        .adc_bits_i    (adc_bits),
        .bist_bits_i   (bist_bits),
        .sel_src_i     (sel_src),
        .check_en_i    (check_en),
        .clr_i         (chk_clr),
        .err_count_o   (prbs_err_count_o),
        .total_count_o (prbs_total_count_o)
    );

    pi_ctl_scale pi_ctl_scale_i (
        .clk_adc        (clk_adc),
        .cdr_rstb       (cdr_rstb),
        .pi_code_i      (pi_code_i),
        .max_sel_i      (max_sel_i),
        .ext_scale_en_i (ext_scale_en_i),
        .ext_scale_i    (ext_scale_i),
        .pi_offset_i    (pi_offset_i),
        .pi_ctl_o       (pi_ctl_o)
    );

endmodule

`default_nettype wire

//--- bench/tb_rx_core.sv
`timescale 1ns/1ps
`default_nettype none

`include "rx_core_settings.svh"

module tb_rx_core;
    import adc_pkg::*;
    import ctl_pkg::*;

    localparam int CLK_PERIOD   = 8;
    localparam int SEED         = 89;
    localparam int WAKE_CYCLES  = 40;
    localparam int CLEAN_CYCLES = 120;
    localparam int INJ_PULSES   = 12;
    localparam int INJ_GAP_MAX  = 9;
    localparam int ADC_CYCLES   = 120;
    localparam int NOISE_CYCLES = 24;
    localparam int TAIL_CYCLES  = 16;
    localparam int TEST_CYCLES  = 3 + WAKE_CYCLES + CLEAN_CYCLES
                                + INJ_PULSES * (INJ_GAP_MAX + 1) + ADC_CYCLES
                                + NOISE_CYCLES + TAIL_CYCLES + 16;
    localparam int TIMEOUT_CYCLES = TEST_CYCLES + 100;

    logic       clk_adc;
    logic       cdr_rstb;
    adc_mag_t   adc_mag [`RX_NTI-1:0];
    lane_bits_t adc_sign;
    offset_t    adc_offset;
    unfolded_t  slice_thresh;
    prbs_src_e  prbs_src;
    logic       chk_en;
    logic       chk_clear;
    logic       gen_en;
    logic       gen_inj_err;
    pi_code_t   pi_code [`RX_NOUT-1:0];
    max_sel_t   max_sel [`RX_NOUT-1:0];
    logic       ext_scale_en;
    pi_code_t   ext_scale [`RX_NOUT-1:0];
    pi_code_t   pi_offset [`RX_NOUT-1:0];
    logic       ctl_valid;
    unfolded_t  unfolded [`RX_NTI-1:0];
    count_t     err_count;
    count_t     total_count;
    pi_code_t   pi_ctl [`RX_NOUT-1:0];

    // test phase flags
    logic bist_clean;
    logic err_model_on;
    logic adc_clean;
    logic noise_check;
    logic adc_prbs_mode;

    // reference model state
    int         edges_since_rst;
    adc_mag_t   mag_q [`RX_NTI-1:0];
    lane_bits_t sign_q;
    offset_t    off_q;
    pi_code_t   code_q [`RX_NOUT-1:0];
    max_sel_t   sel_q [`RX_NOUT-1:0];
    logic       ext_en_q;
    pi_code_t   ext_q [`RX_NOUT-1:0];
    pi_code_t   poff_q [`RX_NOUT-1:0];
    prbs_src_e  src_q;
    logic       clr_seen;
    logic       inj_d1;
    count_t     exp_err;
    logic [4:0] tick;
    count_t     grow_ref;
    logic       grow_armed;
    logic [6:0] prbs_state;
    unfolded_t  exp_unf [`RX_NTI-1:0];
    pi_code_t   exp_pi [`RX_NOUT-1:0];

    rx_core_top rx_core_top_i (
        .clk_adc            (clk_adc),
        .cdr_rstb           (cdr_rstb),
        .adc_mag_i          (adc_mag),
        .adc_sign_i         (adc_sign),
        .adc_offset_i       (adc_offset),
        .slice_thresh_i     (slice_thresh),
        .prbs_src_i         (prbs_src),
        .chk_en_i           (chk_en),
        .chk_clear_i        (chk_clear),
        .gen_en_i           (gen_en),
        .gen_inj_err_i      (gen_inj_err),
        .pi_code_i          (pi_code),
        .max_sel_i          (max_sel),
        .ext_scale_en_i     (ext_scale_en),
        .ext_scale_i        (ext_scale),
        .pi_offset_i        (pi_offset),
        .ctl_valid_o        (ctl_valid),
        .unfolded_o         (unfolded),
        .prbs_err_count_o   (err_count),
        .prbs_total_count_o (total_count),
        .pi_ctl_o           (pi_ctl)
    );

    ////////////////////////////////////////////////////////////
    // helpers
    ////////////////////////////////////////////////////////////

    task automatic fail_with(input string msg);
        $display("%s", msg);
        $display("SIMULATION FAILED");
        $fatal(1, "run stopped at the first failing check");
    endtask

    // sign 1 is positive, result kept in the 9-bit code width
    function automatic unfolded_t unfold_expect(input adc_mag_t mag, input logic pos,
                                                input offset_t off);
        int value;
        value = pos ? int'(mag) : -int'(mag);
        value = value - int'(off);
        return unfolded_t'(value);
    endfunction

    function automatic pi_code_t pi_scale_expect(input pi_code_t code, input max_sel_t sel,
                                                 input logic ext_en, input pi_code_t ext,
                                                 input pi_code_t offset);
        int scale;
        if (ext_en) begin
            scale = int'(ext);
        end else begin
            scale = (int'(sel) + 1) * (1 << `RX_SCALE_SHIFT) - 1;
        end
        return pi_code_t'(int'(code) % scale + int'(offset));
    endfunction

    // prbs7, bit[0] of state is 7 back and bit[1] is 6 back
    task automatic next_prbs_word(output lane_bits_t word);
        logic nb;
        for (int i = 0; i < `RX_NTI; i++) begin
            nb         = prbs_state[0] ^ prbs_state[1];
            word[i]    = nb;
            prbs_state = {nb, prbs_state[6:1]};
        end
    endtask

    task automatic init_inputs();
        cdr_rstb      = 1'b0;
        adc_sign      = '0;
        adc_offset    = '0;
        slice_thresh  = '0;
        prbs_src      = SRC_ADC;
        chk_en        = 1'b0;
        chk_clear     = 1'b0;
        gen_en        = 1'b0;
        gen_inj_err   = 1'b0;
        ext_scale_en  = 1'b0;
        bist_clean    = 1'b0;
        err_model_on  = 1'b0;
        adc_clean     = 1'b0;
        noise_check   = 1'b0;
        adc_prbs_mode = 1'b0;
        prbs_state    = 7'($urandom_range(127, 1));
        for (int k = 0; k < `RX_NTI; k++) begin
            adc_mag[k] = '0;
        end
        for (int j = 0; j < `RX_NOUT; j++) begin
            pi_code[j]   = '0;
            max_sel[j]   = '0;
            ext_scale[j] = pi_code_t'(1);
            pi_offset[j] = '0;
        end
    endtask

    // one cycle of traffic, strobes drop back to 0
    task automatic drive_cycle();
        lane_bits_t word;
        @(posedge clk_adc);
        #1;
        if (adc_prbs_mode) begin
            next_prbs_word(word);
            adc_sign   = word;
            adc_offset = '0;
            for (int k = 0; k < `RX_NTI; k++) begin
                adc_mag[k] = adc_mag_t'($urandom_range((1 << `RX_NADC) - 1, 1));
            end
        end else begin
            adc_sign   = lane_bits_t'($urandom);
            adc_offset = offset_t'($urandom);
            for (int k = 0; k < `RX_NTI; k++) begin
                adc_mag[k] = adc_mag_t'($urandom);
            end
        end
        for (int j = 0; j < `RX_NOUT; j++) begin
            pi_code[j]   = pi_code_t'($urandom);
            max_sel[j]   = max_sel_t'($urandom);
            ext_scale[j] = pi_code_t'($urandom_range((1 << `RX_NPI) - 1, 1));
            pi_offset[j] = pi_code_t'($urandom);
        end
        ext_scale_en = 1'($urandom);
        gen_inj_err  = 1'b0;
        chk_clear    = 1'b0;
    endtask

    ////////////////////////////////////////////////////////////
    // reference models
    ////////////////////////////////////////////////////////////

    always @(posedge clk_adc or negedge cdr_rstb) begin
        if (!cdr_rstb) begin
            edges_since_rst <= 0;
            sign_q          <= '0;
            off_q           <= '0;
            ext_en_q        <= 1'b0;
            src_q           <= SRC_ADC;
            clr_seen        <= 1'b0;
            inj_d1          <= 1'b0;
            exp_err         <= '0;
            for (int k = 0; k < `RX_NTI; k++) begin
                mag_q[k] <= '0;
            end
            for (int j = 0; j < `RX_NOUT; j++) begin
                code_q[j] <= '0;
                sel_q[j]  <= '0;
                ext_q[j]  <= '0;
                poff_q[j] <= '0;
            end
        end else begin
            if (edges_since_rst < 100) begin
                edges_since_rst <= edges_since_rst + 1;
            end
            sign_q   <= adc_sign;
            off_q    <= adc_offset;
            ext_en_q <= ext_scale_en;
            for (int k = 0; k < `RX_NTI; k++) begin
                mag_q[k] <= adc_mag[k];
            end
            for (int j = 0; j < `RX_NOUT; j++) begin
                code_q[j] <= pi_code[j];
                sel_q[j]  <= max_sel[j];
                ext_q[j]  <= ext_scale[j];
                poff_q[j] <= pi_offset[j];
            end
            // a source change or a clear strobe empties the checker
            src_q    <= prbs_src;
            clr_seen <= chk_clear || (prbs_src != src_q);
            inj_d1   <= gen_inj_err && gen_en;
            if (chk_clear || (prbs_src != src_q)) begin
                exp_err <= '0;
            end else if (inj_d1) begin
                exp_err <= exp_err + 3;
            end
        end
    end

    // total count snapshot every 32 cycles
    always @(posedge clk_adc or negedge cdr_rstb) begin
        if (!cdr_rstb) begin
            tick       <= '0;
            grow_ref   <= '0;
            grow_armed <= 1'b0;
        end else begin
            tick <= tick + 5'd1;
            if (tick == 5'd0) begin
                grow_ref   <= total_count;
                grow_armed <= bist_clean;
            end
        end
    end

    always_comb begin
        for (int k = 0; k < `RX_NTI; k++) begin
            exp_unf[k] = unfold_expect(mag_q[k], sign_q[k], off_q);
        end
        for (int j = 0; j < `RX_NOUT; j++) begin
            exp_pi[j] = pi_scale_expect(code_q[j], sel_q[j], ext_en_q, ext_q[j], poff_q[j]);
        end
    end

    ////////////////////////////////////////////////////////////
    // checks, sampled mid-cycle
    ////////////////////////////////////////////////////////////

    a_ctl_valid: assert property (@(negedge clk_adc) disable iff (!cdr_rstb)
        ctl_valid == (edges_since_rst >= `RX_CTL_WAIT))
    else fail_with($sformatf("** Error at %0t: ctl_valid_o expected %0d, actual %0d",
        $time, edges_since_rst >= `RX_CTL_WAIT, ctl_valid));

    for (genvar k = 0; k < `RX_NTI; k++) begin : g_lane_chk
        a_unfold: assert property (@(negedge clk_adc) disable iff (!cdr_rstb)
            unfolded[k] == exp_unf[k])
        else fail_with($sformatf("** Error at %0t: unfolded_o[%0d] expected %0d, actual %0d",
            $time, k, exp_unf[k], unfolded[k]));
    end

    for (genvar j = 0; j < `RX_NOUT; j++) begin : g_pi_chk
        a_pi_ctl: assert property (@(negedge clk_adc) disable iff (!cdr_rstb)
            pi_ctl[j] == exp_pi[j])
        else fail_with($sformatf("** Error at %0t: pi_ctl_o[%0d] expected %0d, actual %0d",
            $time, j, exp_pi[j], pi_ctl[j]));
    end

    a_total_step: assert property (@(negedge clk_adc) disable iff (!cdr_rstb)
        (total_count % `RX_NTI) == 0)
    else fail_with($sformatf(
        "** Error at %0t: prbs_total_count_o expected a multiple of %0d, actual %0d",
        $time, `RX_NTI, total_count));

    a_bist_clean: assert property (@(negedge clk_adc) disable iff (!cdr_rstb)
        !bist_clean || (err_count == '0))
    else fail_with($sformatf("** Error at %0t: prbs_err_count_o expected 0, actual %0d",
        $time, err_count));

    a_total_grows: assert property (@(negedge clk_adc) disable iff (!cdr_rstb)
        !(bist_clean && grow_armed && (tick == 5'd16)) || (total_count > grow_ref))
    else fail_with($sformatf("total bit count did not grow, still %0d after %0d at %0t",
        total_count, grow_ref, $time));

    a_inj_errors: assert property (@(negedge clk_adc) disable iff (!cdr_rstb)
        !err_model_on || (err_count == exp_err))
    else fail_with($sformatf("** Error at %0t: prbs_err_count_o expected %0d, actual %0d",
        $time, exp_err, err_count));

    a_clear_err: assert property (@(negedge clk_adc) disable iff (!cdr_rstb)
        !clr_seen || (err_count == '0))
    else fail_with($sformatf("** Error at %0t: prbs_err_count_o expected 0, actual %0d",
        $time, err_count));

    a_clear_total: assert property (@(negedge clk_adc) disable iff (!cdr_rstb)
        !clr_seen || (total_count == '0))
    else fail_with($sformatf("** Error at %0t: prbs_total_count_o expected 0, actual %0d",
        $time, total_count));

    a_adc_clean: assert property (@(negedge clk_adc) disable iff (!cdr_rstb)
        !adc_clean || (err_count == '0))
    else fail_with($sformatf("** Error at %0t: prbs_err_count_o expected 0, actual %0d",
        $time, err_count));

    a_noise_seen: assert property (@(negedge clk_adc) disable iff (!cdr_rstb)
        !noise_check || (err_count != '0))
    else fail_with("random ADC signs produced no checker errors");

    ////////////////////////////////////////////////////////////
    // clock, stimulus and watchdog
    ////////////////////////////////////////////////////////////

    initial begin
        clk_adc = 1'b0;
        forever #(CLK_PERIOD / 2) clk_adc = ~clk_adc;
    end

    initial begin
        #(TIMEOUT_CYCLES * CLK_PERIOD);
        fail_with("watchdog expired before the test sequence finished");
    end

    initial begin
        int gap;
        void'($urandom(SEED));
        init_inputs();
        repeat (3) @(posedge clk_adc);
        #1;
        cdr_rstb = 1'b1;
        repeat (WAKE_CYCLES) drive_cycle();

        // bist loopback, source change clears the counters
        prbs_src = SRC_BIST;
        gen_en   = 1'b1;
        chk_en   = 1'b1;
        drive_cycle();
        bist_clean   = 1'b1;
        err_model_on = 1'b1;
        repeat (CLEAN_CYCLES) drive_cycle();

        // isolated injected errors, one clear strobe halfway
        bist_clean = 1'b0;
        for (int p = 0; p < INJ_PULSES; p++) begin
            drive_cycle();
            gen_inj_err = 1'b1;
            gap = $urandom_range(INJ_GAP_MAX, 4);
            repeat (gap) drive_cycle();
            if (p == INJ_PULSES / 2) begin
                chk_clear = 1'b1;
                repeat (4) drive_cycle();
            end
        end
        err_model_on = 1'b0;

        // adc path carrying the prbs model, then noise
        adc_prbs_mode = 1'b1;
        repeat (4) drive_cycle();
        prbs_src = SRC_ADC;
        drive_cycle();
        adc_clean = 1'b1;
        repeat (ADC_CYCLES) drive_cycle();
        adc_clean     = 1'b0;
        adc_prbs_mode = 1'b0;
        repeat (NOISE_CYCLES) drive_cycle();
        noise_check = 1'b1;
        drive_cycle();
        noise_check = 1'b0;
        prbs_src    = SRC_BIST;
        repeat (TAIL_CYCLES) drive_cycle();

        @(negedge clk_adc);
        #1;
        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

`default_nettype wire

//--- all.f
+incdir+common
common/adc_pkg.sv
common/ctl_pkg.sv
source/rx_control.sv
source/adc_unfold_slice.sv
source/pi_ctl_scale.sv
prbs/prbs_bist_gen.sv
prbs/prbs_rx_checker.sv
source/rx_core_top.sv
bench/tb_rx_core.sv

//--- run_sim.sh
#!/bin/sh
# Build the rx core testbench with Verilator and run it.
# Exit status is 0 only when the pass message shows up in the output.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module tb_rx_core -f all.f --Mdir obj_dir -o sim_rx_core
if [ $? -ne 0 ]; then
    echo "run_sim: verilator build failed"
    exit 1
fi

sim_out=$(./obj_dir/sim_rx_core 2>&1)
sim_status=$?
printf '%s\n' "$sim_out"
if [ $sim_status -ne 0 ]; then
    echo "run_sim: simulation exited with status $sim_status"
    exit 1
fi

if printf '%s\n' "$sim_out" | grep -q '^SIMULATION PASSED$'; then
    exit 0
fi
echo "run_sim: pass message not found"
exit 1
